//--- project.f
src/render_pkg.sv
src/pix_inc.sv
src/dispatch.sv
src/pixel_worker.sv
src/result_collect.sv
src/render_top.sv
test/render_asserts.sv
test/render_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the renderer testbench with Verilator and runs it.
# Exit status is zero only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module render_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vrender_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

//--- test/render_tb.sv
//~~~~~~~~~~~~~~~~~~~~
// Testbench for the fractal renderer.
// Runs frames under several sink credit patterns and checks each pixel.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module render_tb import render_pkg::*; ();

	localparam int NUM_PIX = IMG_W * IMG_H;
	localparam int TIMEOUT = 8000;

	logic               clk = 1'b0;
	logic               n_rst = 1'b0;
	logic               start = 1'b0;
	logic               pix_credit = 1'b0;
	logic               pix_valid;
	logic [COORD_W-1:0] pix_x;
	logic [COORD_W-1:0] pix_y;
	logic [ITER_W-1:0]  pix_iter;
	logic               frame_done;

	// Sink controls change on the falling edge only
	bit    hold_credits = 1'b0;
	bit    random_delay = 1'b0;
	string test_name = "reset";
	bit    seen [int];
	int    frame_pix = 0;
	int    emitted = 0;
	int    returned = 0;
	int    check_errors = 0;
	int    main_errors = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	bit    timed_out = 1'b0;

	render_top render_top_inst (.*);

	always #20 clk = ~clk;

	// Escape-time count by the worker's fixed-point rule
	function automatic int mandel_iter(input int px, input int py);
		int c_re;
		int c_im;
		int zr;
		int zi;
		int zr2;
		int zi2;
		int zri;
		int n;
		c_re = int'(X0) + px * int'(STEP_X);
		c_im = int'(Y0) + py * int'(STEP_Y);
		zr = 0;
		zi = 0;
		for (n = 0; n < MAX_ITER; n++) begin
			zr2 = int'((longint'(zr) * longint'(zr)) >>> FRAC_W);
			zi2 = int'((longint'(zi) * longint'(zi)) >>> FRAC_W);
			zri = int'((longint'(zr) * longint'(zi)) >>> FRAC_W);
			if (zr2 + zi2 > int'(ESCAPE_LIM))
				break;
			zr = zr2 - zi2 + c_re;
			zi = 2 * zri + c_im;
		end
		return n;
	endfunction

	// Sink model returns at most one credit per cycle
	initial begin
		int due [$];
		int cycle_cnt;
		cycle_cnt = 0;
		void'($urandom(47947));
		forever begin
			@(posedge clk);
			cycle_cnt++;
			if (n_rst && pix_valid)
				due.push_back(cycle_cnt + (random_delay ? int'($urandom % 8) : 0));
			if (!hold_credits && due.size() > 0 && due[0] <= cycle_cnt) begin
				void'(due.pop_front());
				pix_credit <= 1'b1;
			end else begin
				pix_credit <= 1'b0;
			end
		end
	end

	// Every emitted pixel against the reference
	always @(posedge clk) begin
		int expected;
		int key;
		if (pix_credit)
			returned++;
		if (start) begin
			seen.delete();
			frame_pix = 0;
		end
		if (n_rst && pix_valid) begin
			emitted++;
			frame_pix++;
			key = int'(pix_y) * IMG_W + int'(pix_x);
			expected = mandel_iter(int'(pix_x), int'(pix_y));
			assert (int'(pix_x) < IMG_W && int'(pix_y) < IMG_H) else begin
				$display("%s: pixel (%0d,%0d) lies outside the image",
					test_name, pix_x, pix_y);
				check_errors++;
			end
			assert (int'(pix_iter) == expected) else begin
				$display("FAIL %s: pixel (%0d,%0d) expected %0d actual %0d",
					test_name, pix_x, pix_y, expected, pix_iter);
				check_errors++;
			end
			assert (!seen.exists(key)) else begin
				$display("%s: pixel (%0d,%0d) was sent twice", test_name, pix_x, pix_y);
				check_errors++;
			end
			assert (emitted - returned <= OUT_CREDITS) else begin
				$display("%s: more pixels sent than the sink gave credits for", test_name);
				check_errors++;
			end
			seen[key] = 1'b1;
		end
	end

	// One frame with an optional credit hold after hold_after pixels
	task automatic run_test(input string name, input int hold_after, input bit rnd);
		int cycles;
		int held;
		int base_errors;
		int errs;
		test_name = name;
		base_errors = main_errors + check_errors;
		random_delay = rnd;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		assert (!frame_done) else begin
			$display("%s: frame_done still high after start", name);
			main_errors++;
		end
		if (hold_after > 0) begin
			for (cycles = 0; frame_pix < hold_after && cycles < TIMEOUT; cycles++)
				@(negedge clk);
			assert (frame_pix >= hold_after) else begin
				$display("%s: timed out before credits were withheld", name);
				main_errors++;
			end
			hold_credits = 1'b1;
			held = frame_pix;
			repeat (200) @(negedge clk);
			assert (frame_pix - held <= OUT_CREDITS) else begin
				$display("FAIL %s: pixels while withheld expected <= %0d actual %0d",
					name, OUT_CREDITS, frame_pix - held);
				main_errors++;
			end
			hold_credits = 1'b0;
		end
		for (cycles = 0; !frame_done && cycles < TIMEOUT; cycles++)
			@(negedge clk);
		assert (frame_done) else begin
			$display("%s: timed out waiting for frame_done", name);
			main_errors++;
			timed_out = 1'b1;
		end
		assert (frame_pix == NUM_PIX) else begin
			$display("FAIL %s: pixel count expected %0d actual %0d", name, NUM_PIX, frame_pix);
			main_errors++;
		end
		errs = main_errors + check_errors - base_errors;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("test %s finished with %0d errors", name, errs);
	endtask

	initial begin
		int cycles;
		int errs;
		repeat (3) @(posedge clk);
		n_rst <= 1'b1;
		for (cycles = 0; cycles < 20; cycles++) begin
			@(negedge clk);
			assert (!pix_valid && !frame_done) else begin
				$display("%s: outputs active before any start", test_name);
				main_errors++;
			end
		end
		errs = main_errors + check_errors;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("test %s finished with %0d errors", test_name, errs);
		run_test("full_frame_fast", 0, 1'b0);
		if (!timed_out)
			run_test("back_pressure", 40, 1'b0);
		if (!timed_out)
			run_test("random_credit", 0, 1'b1);
		if (!timed_out)
			run_test("second_frame", 0, 1'b0);
		$display("summary: %0d tests, %0d failed, %0d errors",
			tests_run, tests_failed, main_errors + check_errors);
		if (main_errors + check_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- test/render_asserts.sv
//~~~~~~~~~~~~~~~~~~~~
// Dispatch and sink credit checks, bound into render_top.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module render_asserts import render_pkg::*; (
	input logic                   clk,
	input logic                   n_rst,
	input logic [NUM_WORKERS-1:0] dp_jw_start,
	input logic [NUM_WORKERS-1:0] jw_dp_ready,
	input logic [NUM_WORKERS-1:0] res_take,
	input logic                   pix_credit,
	input logic                   pix_valid,
	input logic                   frame_done
);

	// Sink credits as the collector should hold them
	int credits;

	always_ff @(posedge clk) begin
		if (!n_rst)
			credits <= OUT_CREDITS;
		else
			credits <= credits - int'(|res_take) + int'(pix_credit);
	end

	start_onehot: assert property (@(posedge clk) disable iff (!n_rst)
		$onehot0(dp_jw_start))
		else $error("more than one worker started at once");

	start_ready: assert property (@(posedge clk) disable iff (!n_rst)
		(dp_jw_start & ~jw_dp_ready) == '0)
		else $error("busy worker was started");

	credit_used: assert property (@(posedge clk) disable iff (!n_rst)
		pix_valid |-> ($past(credits) > 0))
		else $error("pixel sent with no sink credit");

	done_quiet: assert property (@(posedge clk) disable iff (!n_rst)
		!(frame_done && pix_valid))
		else $error("frame_done high while a pixel is sent");

endmodule

bind render_top render_asserts render_asserts_inst (
	.clk         (clk),
	.n_rst       (n_rst),
	.dp_jw_start (dp_jw_start),
	.jw_dp_ready (jw_dp_ready),
	.res_take    (res_take),
	.pix_credit  (pix_credit),
	.pix_valid   (pix_valid),
	.frame_done  (frame_done)
);

//--- src/render_top.sv
//~~~~~~~~~~~~~~~~~~~~
// Renderer top level: raster counter, dispatcher, worker pool, collector.
// Pulse start for a frame; pixels stream out under sink credit.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module render_top import render_pkg::*; (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               start,
	input  logic               pix_credit,
	output logic               pix_valid,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	output logic [ITER_W-1:0]  pix_iter,
	output logic               frame_done
);

	logic                                clear;
	logic                                pix_step;
	logic [COORD_W-1:0]                  x;
	logic [COORD_W-1:0]                  y;
	logic                                last;
	logic [NUM_WORKERS-1:0]              jw_dp_ready;
	logic [NUM_WORKERS-1:0]              dp_jw_start;
	logic [COORD_W-1:0]                  job_x;
	logic [COORD_W-1:0]                  job_y;
	logic [NUM_WORKERS-1:0]              res_valid;
	logic [NUM_WORKERS-1:0]              res_take;
	logic [NUM_WORKERS-1:0][COORD_W-1:0] res_x;
	logic [NUM_WORKERS-1:0][COORD_W-1:0] res_y;
	logic [NUM_WORKERS-1:0][ITER_W-1:0]  res_iter;
	logic                                res_pending;

	pix_inc pix_inc_inst (
		.clk      (clk),
		.n_rst    (n_rst),
		.clear    (clear),
		.pix_step (pix_step),
		.x        (x),
		.y        (y),
		.last     (last)
	);

	dispatch dispatch_inst (
		.clk         (clk),
		.n_rst       (n_rst),
		.start       (start),
		.jw_dp_ready (jw_dp_ready),
		.res_pending (res_pending),
		.x           (x),
		.y           (y),
		.last        (last),
		.clear       (clear),
		.pix_step    (pix_step),
		.dp_jw_start (dp_jw_start),
		.job_x       (job_x),
		.job_y       (job_y),
		.frame_done  (frame_done)
	);

	// Workers share job_x and job_y; only the started one latches them
	for (genvar i = 0; i < NUM_WORKERS; i++) begin : g_worker
		pixel_worker pixel_worker_inst (
			.clk       (clk),
			.n_rst     (n_rst),
			.go        (dp_jw_start[i]),
			.job_x     (job_x),
			.job_y     (job_y),
			.take      (res_take[i]),
			.ready     (jw_dp_ready[i]),
			.res_valid (res_valid[i]),
			.res_x     (res_x[i]),
			.res_y     (res_y[i]),
			.res_iter  (res_iter[i])
		);
	end

	result_collect result_collect_inst (
		.clk         (clk),
		.n_rst       (n_rst),
		.res_valid   (res_valid),
		.res_x       (res_x),
		.res_y       (res_y),
		.res_iter    (res_iter),
		.pix_credit  (pix_credit),
		.res_take    (res_take),
		.res_pending (res_pending),
		.pix_valid   (pix_valid),
		.pix_x       (pix_x),
		.pix_y       (pix_y),
		.pix_iter    (pix_iter)
	);

endmodule

//--- src/result_collect.sv
//~~~~~~~~~~~~~~~~~~~~
// Drains finished workers towards the sink.
// One result per cycle while sink credit remains.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module result_collect import render_pkg::*; (
	input  logic                                clk,
	input  logic                                n_rst,
	input  logic [NUM_WORKERS-1:0]              res_valid,
	input  logic [NUM_WORKERS-1:0][COORD_W-1:0] res_x,
	input  logic [NUM_WORKERS-1:0][COORD_W-1:0] res_y,
	input  logic [NUM_WORKERS-1:0][ITER_W-1:0]  res_iter,
	input  logic                                pix_credit,
	output logic [NUM_WORKERS-1:0]              res_take,
	output logic                                res_pending,
	output logic                                pix_valid,
	output logic [COORD_W-1:0]                  pix_x,
	output logic [COORD_W-1:0]                  pix_y,
	output logic [ITER_W-1:0]                   pix_iter
);

	logic [CREDIT_W-1:0]    credit;
	logic [NUM_WORKERS-1:0] pick;
	logic                   found;
	logic                   can_send;
	logic                   take_any;

	always_comb begin
		pick  = '0;
		found = 1'b0;
		for (int i = 0; i < NUM_WORKERS; i++) begin
			if (res_valid[i] && !found) begin
				pick[i] = 1'b1;
				found   = 1'b1;
			end
		end
	end

	assign can_send    = (credit != '0);
	assign take_any    = found && can_send;
	assign res_take    = can_send ? pick : '0;
	assign res_pending = |res_valid;

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			credit    <= CREDIT_W'(OUT_CREDITS);
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= take_any;
			// Emit and return may land in the same cycle
			case ({take_any, pix_credit})
				2'b10:   credit <= credit - 1'b1;
				2'b01:   credit <= credit + 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	// One-hot select of the taken worker's payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_WORKERS; i++) begin
			if (res_take[i]) begin
				pix_x    <= res_x[i];
				pix_y    <= res_y[i];
				pix_iter <= res_iter[i];
			end
		end
	end

endmodule

//--- src/pixel_worker.sv
//~~~~~~~~~~~~~~~~~~~~
// Mandelbrot iteration for one pixel, one step per cycle.
// Result is held with its coordinates until take.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pixel_worker import render_pkg::*; (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               go,
	input  logic [COORD_W-1:0] job_x,
	input  logic [COORD_W-1:0] job_y,
	input  logic               take,
	output logic               ready,
	output logic               res_valid,
	output logic [COORD_W-1:0] res_x,
	output logic [COORD_W-1:0] res_y,
	output logic [ITER_W-1:0]  res_iter
);

	logic                      busy;
	logic                      stop;
	logic signed [FIX_W-1:0]   c_re;
	logic signed [FIX_W-1:0]   c_im;
	logic signed [FIX_W-1:0]   zr;
	logic signed [FIX_W-1:0]   zi;
	logic signed [2*FIX_W-1:0] p_rr;
	logic signed [2*FIX_W-1:0] p_ii;
	logic signed [2*FIX_W-1:0] p_ri;
	logic signed [FIX_W-1:0]   zr2;
	logic signed [FIX_W-1:0]   zi2;
	logic signed [FIX_W-1:0]   zri;
	logic signed [FIX_W-1:0]   mag;

	assign p_rr = zr * zr;
	assign p_ii = zi * zi;
	assign p_ri = zr * zi;

	// Back to FRAC_W fractional bits
	assign zr2 = p_rr[FRAC_W +: FIX_W];
	assign zi2 = p_ii[FRAC_W +: FIX_W];
	assign zri = p_ri[FRAC_W +: FIX_W];

	assign mag  = zr2 + zi2;
	assign stop = (mag > ESCAPE_LIM) || (res_iter == ITER_W'(MAX_ITER));

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			ready     <= 1'b1;
			busy      <= 1'b0;
			res_valid <= 1'b0;
		end else if (go) begin
			ready <= 1'b0;
			busy  <= 1'b1;
		end else if (busy && stop) begin
			busy      <= 1'b0;
			res_valid <= 1'b1;
		end else if (take) begin
			res_valid <= 1'b0;
			ready     <= 1'b1;
		end
	end

	// res_iter doubles as the running count
	always_ff @(posedge clk) begin
		if (go) begin
			c_re     <= X0 + $signed(FIX_W'(job_x)) * STEP_X;
			c_im     <= Y0 + $signed(FIX_W'(job_y)) * STEP_Y;
			zr       <= '0;
			zi       <= '0;
			res_iter <= '0;
			res_x    <= job_x;
			res_y    <= job_y;
		end else if (busy && !stop) begin
			zr       <= zr2 - zi2 + c_re;
			zi       <= (zri <<< 1) + c_im;
			res_iter <= res_iter + 1'b1;
		end
	end

endmodule

//--- src/dispatch.sv
//~~~~~~~~~~~~~~~~~~~~
// Hands each pixel to the lowest-index idle worker.
// One launch per SEARCH, REST, ASSIGN pass; frame_done after the drain.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dispatch import render_pkg::*; (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   start,
	input  logic [NUM_WORKERS-1:0] jw_dp_ready,
	input  logic                   res_pending,
	input  logic [COORD_W-1:0]     x,
	input  logic [COORD_W-1:0]     y,
	input  logic                   last,
	output logic                   clear,
	output logic                   pix_step,
	output logic [NUM_WORKERS-1:0] dp_jw_start,
	output logic [COORD_W-1:0]     job_x,
	output logic [COORD_W-1:0]     job_y,
	output logic                   frame_done
);

	typedef enum logic [2:0] {IDLE, SEARCH, REST, ASSIGN, DONE} state_t;

	state_t                 state;
	state_t                 next_state;
	logic [NUM_WORKERS-1:0] pick;
	logic                   found;
	logic                   drained;

	// Lowest ready index wins
	always_comb begin
		pick  = '0;
		found = 1'b0;
		for (int i = 0; i < NUM_WORKERS; i++) begin
			if (jw_dp_ready[i] && !found) begin
				pick[i] = 1'b1;
				found   = 1'b1;
			end
		end
	end

	assign drained  = (&jw_dp_ready) && !res_pending;
	assign clear    = (state == IDLE) && start;
	assign pix_step = (state == ASSIGN);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (start)
					next_state = SEARCH;
			end
			SEARCH: begin
				if (found)
					next_state = REST;
			end
			REST: begin
				next_state = ASSIGN;
			end
			ASSIGN: begin
				next_state = last ? DONE : SEARCH;
			end
			DONE: begin
				if (drained)
					next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			state       <= IDLE;
			dp_jw_start <= '0;
			frame_done  <= 1'b0;
		end else begin
			state <= next_state;
			// Start bit is high for the REST cycle only
			dp_jw_start <= (state == SEARCH && found) ? pick : '0;
			if (clear)
				frame_done <= 1'b0;
			else if (state == DONE && drained)
				frame_done <= 1'b1;
		end
	end

	// Coordinate for the worker picked this cycle
	always_ff @(posedge clk) begin
		if (state == SEARCH && found) begin
			job_x <= x;
			job_y <= y;
		end
	end

endmodule

//--- src/pix_inc.sv
//~~~~~~~~~~~~~~~~~~~~
// Raster counter over the image, x fastest.
// Steps once per pix_step, clear returns to (0,0).
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pix_inc import render_pkg::*; (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               clear,
	input  logic               pix_step,
	output logic [COORD_W-1:0] x,
	output logic [COORD_W-1:0] y,
	output logic               last
);

	logic x_end;
	logic y_end;

	assign x_end = (x == COORD_W'(IMG_W - 1));
	assign y_end = (y == COORD_W'(IMG_H - 1));
	assign last  = x_end && y_end;

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			x <= '0;
			y <= '0;
		end else if (clear) begin
			x <= '0;
			y <= '0;
		end else if (pix_step) begin
			if (x_end) begin
				x <= '0;
				// Wraps back to row 0 after the final pixel
				y <= y_end ? '0 : y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

endmodule

//--- src/render_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// Shared constants for the fractal renderer.
// Image size, worker count, fixed-point format and credit depth.
//~~~~~~~~~~~~~~~~~~~~
package render_pkg;

	// Image and worker pool
	localparam int NUM_WORKERS = 16;
	localparam int COORD_W     = 10;
	localparam int IMG_W       = 16;
	localparam int IMG_H       = 8;

	// Signed fixed point, Q19.12
	localparam int FRAC_W = 12;
	localparam int FIX_W  = 32;

	// Plane origin of pixel (0,0)
	localparam logic signed [FIX_W-1:0] X0 = -(2 <<< FRAC_W);
	localparam logic signed [FIX_W-1:0] Y0 = -(1 <<< FRAC_W);

	// 3.0 wide over IMG_W pixels, 2.0 high over IMG_H pixels
	localparam logic signed [FIX_W-1:0] STEP_X = (3 <<< FRAC_W) / IMG_W;
	localparam logic signed [FIX_W-1:0] STEP_Y = (2 <<< FRAC_W) / IMG_H;

	// Escape radius squared
	localparam logic signed [FIX_W-1:0] ESCAPE_LIM = 4 <<< FRAC_W;

	localparam int MAX_ITER = 31;
	localparam int ITER_W   = 5;

	// Sink side flow control
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_W    = 3;

endpackage
